//--- source/rename_pkg.sv
// Rename stage package with sizes, tag types and the request/result/retire structs
`default_nettype none

package rename_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////
  localparam int RENAME_WIDTH  = 2;
  localparam int ARCH_REGS     = 32;
  localparam int ARCH_IDX_BITS = $clog2(ARCH_REGS);
  localparam int PHYS_REGS     = 64;
  localparam int PHYS_IDX_BITS = $clog2(PHYS_REGS);

  // Every physical tag not mapped at reset starts in the free list
  localparam int FREE_DEPTH    = PHYS_REGS - ARCH_REGS;
  localparam int FREE_PTR_BITS = $clog2(FREE_DEPTH) + 1;

  localparam int CKPT_DEPTH    = 4;
  localparam int CKPT_IDX_BITS = $clog2(CKPT_DEPTH);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////
  typedef logic [ARCH_IDX_BITS-1:0] arch_idx_t;
  typedef logic [PHYS_IDX_BITS-1:0] phys_idx_t;

  typedef struct packed {
    logic      valid;
    logic      has_rd;
    arch_idx_t rs1;
    arch_idx_t rs2;
    arch_idx_t rd;
  } rename_slot_t;

  typedef struct packed {
    rename_slot_t [RENAME_WIDTH-1:0] slot;
    logic                            take_check;
  } rename_req_t;

  typedef struct packed {
    phys_idx_t prs1;
    phys_idx_t prs2;
    phys_idx_t prd;
    phys_idx_t prev_prd;
  } rename_out_t;

  typedef struct packed {
    rename_out_t [RENAME_WIDTH-1:0] out;
    logic [CKPT_IDX_BITS-1:0]       check_idx;
  } rename_result_t;

  typedef struct packed {
    logic      valid;
    phys_idx_t free_tag;
  } retire_slot_t;

  typedef struct packed {
    retire_slot_t [RENAME_WIDTH-1:0] slot;
  } retire_t;

  // Whole map, entry i holds the tag of architectural register i
  typedef logic [ARCH_REGS-1:0][PHYS_IDX_BITS-1:0] map_snapshot_t;

  typedef logic [FREE_PTR_BITS-1:0] free_ptr_t;

endpackage

`default_nettype wire

//--- source/rename_map_table.sv
// Rename map table with group lookup, intra-group bypass, update and snapshot restore
`timescale 1ns/10ps
`default_nettype none

module rename_map_table import rename_pkg::*; (
  input  logic                           clock,
  input  logic                           reset,
  input  rename_req_t                    rename_req,
  input  logic                           enable,
  input  phys_idx_t [RENAME_WIDTH-1:0]   alloc_tags,
  input  logic                           restore,
  input  map_snapshot_t                  restore_map,
  output logic [1:0]                     alloc_count,
  output rename_out_t [RENAME_WIDTH-1:0] rename_out,
  output map_snapshot_t                  next_map
);

  map_snapshot_t map_q;
  map_snapshot_t map_work;
  rename_slot_t  slot;
  logic [1:0]    need;
  logic          writes_rd;

  //////////////////////////////////////////////////
  // Group lookup, slot by slot
  //////////////////////////////////////////////////
  // map_work carries the map as updated by the older slots, which covers
  // both RAW on the sources and WAW on prev_prd
  always_comb begin
    map_work   = map_q;
    need       = 2'd0;
    rename_out = '0;
    slot       = '0;
    writes_rd  = 1'b0;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      slot      = rename_req.slot[s];
      writes_rd = slot.valid && slot.has_rd;

      rename_out[s].prs1 = map_work[slot.rs1];
      rename_out[s].prs2 = map_work[slot.rs2];

      if (writes_rd) begin
        rename_out[s].prev_prd = map_work[slot.rd];
        // Free tags are consumed in queue order across the group
        rename_out[s].prd      = alloc_tags[need[0]];
        map_work[slot.rd]      = alloc_tags[need[0]];
        need                   = need + 2'd1;
      end
    end
  end

  assign alloc_count = need;
  assign next_map    = map_work;

  //////////////////////////////////////////////////
  // Map state
  //////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity mapping, Pi for register i
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= phys_idx_t'(i);
      end
    end else if (restore) begin
      map_q <= restore_map;
    end else if (enable) begin
      map_q <= map_work;
    end
  end

  // Top stalls every group during recovery, so the two never meet
  a_enable_restore_excl : assert property (
    @(posedge clock) disable iff (reset) !(enable && restore)
  );

  // A write through the map always lands on an allocated free-list tag
  a_prd_not_identity : assert property (
    @(posedge clock) disable iff (reset)
    enable && (alloc_count != 2'd0) |-> ##1 (map_q != $past(map_q))
  );

endmodule

`default_nettype wire

//--- source/free_list.sv
// Free list of physical tags as a circular queue with allocate, release and head restore
`timescale 1ns/10ps
`default_nettype none

module free_list import rename_pkg::*; (
  input  logic                         clock,
  input  logic                         reset,
  input  logic [1:0]                   alloc_count,
  input  logic                         alloc_en,
  input  retire_t                      retire,
  input  logic                         restore,
  input  free_ptr_t                    restore_ptr,
  output phys_idx_t [RENAME_WIDTH-1:0] alloc_tags,
  output logic [6:0]                   free_count,
  output free_ptr_t                    next_head
);

  phys_idx_t queue_mem [FREE_DEPTH];

  // Pointers carry one wrap bit above the index
  free_ptr_t head_q;
  free_ptr_t tail_q;
  free_ptr_t next_tail;
  free_ptr_t rd_ptr;
  free_ptr_t [RENAME_WIDTH-1:0] wr_ptr;

  //////////////////////////////////////////////////
  // Allocate side
  //////////////////////////////////////////////////
  always_comb begin
    alloc_tags = '0;
    rd_ptr     = head_q;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
      rd_ptr        = head_q + free_ptr_t'(i);
      alloc_tags[i] = queue_mem[rd_ptr[FREE_PTR_BITS-2:0]];
    end
  end

  assign next_head  = alloc_en ? head_q + free_ptr_t'(alloc_count) : head_q;
  assign free_count = {1'b0, free_ptr_t'(tail_q - head_q)};

  //////////////////////////////////////////////////
  // Release side, slot 0 goes first
  //////////////////////////////////////////////////
  always_comb begin
    next_tail = tail_q;
    wr_ptr    = '0;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      wr_ptr[s] = next_tail;
      if (retire.slot[s].valid) begin
        next_tail = next_tail + free_ptr_t'(1);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // Initial pool is P32 through P63 in order
      for (int i = 0; i < FREE_DEPTH; i++) begin
        queue_mem[i] <= phys_idx_t'(ARCH_REGS + i);
      end
      head_q <= '0;
      tail_q <= free_ptr_t'(FREE_DEPTH);
    end else begin
      head_q <= restore ? restore_ptr : next_head;
      tail_q <= next_tail;
      for (int s = 0; s < RENAME_WIDTH; s++) begin
        if (retire.slot[s].valid) begin
          queue_mem[wr_ptr[s][FREE_PTR_BITS-2:0]] <= retire.slot[s].free_tag;
        end
      end
    end
  end

  a_no_over_alloc : assert property (
    @(posedge clock) disable iff (reset) alloc_en |-> 7'(alloc_count) <= free_count
  );

  a_count_bound : assert property (
    @(posedge clock) disable iff (reset) free_count <= 7'(FREE_DEPTH)
  );

endmodule

`default_nettype wire

//--- source/checkpoint_store.sv
// Checkpoint snapshot memory, one write port and asynchronous read, generic payload
`timescale 1ns/10ps
`default_nettype none

module checkpoint_store import rename_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic                     clock,
  input  logic                     write_en,
  input  logic [CKPT_IDX_BITS-1:0] write_idx,
  input  payload_t                 write_data,
  input  logic [CKPT_IDX_BITS-1:0] read_idx,
  output payload_t                 read_data
);

  // Entries only mean something while the ring marks them live
  payload_t entry_q [CKPT_DEPTH];

  always_ff @(posedge clock) begin
    if (write_en) begin
      entry_q[write_idx] <= write_data;
    end
  end

  // Recovery reads and loads in the same cycle
  assign read_data = entry_q[read_idx];

endmodule

`default_nettype wire

//--- source/checkpoint_ring.sv
// Checkpoint ring that hands out and releases snapshot indices in age order
`timescale 1ns/10ps
`default_nettype none

module checkpoint_ring import rename_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     take,
  input  logic                     release_ckpt,
  input  logic                     recover,
  input  logic [CKPT_IDX_BITS-1:0] recover_idx,
  output logic [CKPT_IDX_BITS-1:0] write_idx,
  output logic                     ring_full,
  output logic                     ring_empty
);

  logic [CKPT_IDX_BITS-1:0] head_q;
  logic [CKPT_IDX_BITS-1:0] tail_q;
  logic [CKPT_IDX_BITS:0]   count_q;
  logic [CKPT_IDX_BITS-1:0] head_next;
  logic [CKPT_IDX_BITS-1:0] live_span;

  assign write_idx  = tail_q;
  assign ring_full  = (count_q == (CKPT_IDX_BITS+1)'(CKPT_DEPTH));
  assign ring_empty = (count_q == '0);

  // Oldest entry leaves on commit, even in a recovery cycle
  assign head_next = release_ckpt ? head_q + 1'b1 : head_q;
  // Distance from the surviving oldest entry to the recovered one
  assign live_span = recover_idx - head_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q <= head_next;
      if (recover) begin
        // Recovered entry stays live, all younger ones are dropped
        tail_q  <= recover_idx + 1'b1;
        count_q <= {1'b0, live_span} + 1'b1;
      end else begin
        if (take) begin
          tail_q <= tail_q + 1'b1;
        end
        count_q <= count_q + {{CKPT_IDX_BITS{1'b0}}, take}
                           - {{CKPT_IDX_BITS{1'b0}}, release_ckpt};
      end
    end
  end

  a_no_release_empty : assert property (
    @(posedge clock) disable iff (reset) release_ckpt |-> !ring_empty
  );

  a_no_take_full : assert property (
    @(posedge clock) disable iff (reset) take |-> !ring_full
  );

endmodule

`default_nettype wire

//--- source/rename_top.sv
// Rename stage top, joins map, free list and checkpoints and forms stall and valid
`timescale 1ns/10ps
`default_nettype none

module rename_top import rename_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  rename_req_t              rename_req,
  input  retire_t                  retire,
  input  logic                     commit_check,
  input  logic                     recover,
  input  logic [CKPT_IDX_BITS-1:0] recover_idx,
  output rename_result_t           rename_result,
  output logic                     result_valid,
  output logic                     rename_stall
);

  logic [1:0]                     alloc_count;
  phys_idx_t [RENAME_WIDTH-1:0]   alloc_tags;
  rename_out_t [RENAME_WIDTH-1:0] rename_out;
  map_snapshot_t                  next_map;
  map_snapshot_t                  restore_map;
  logic [6:0]                     free_count;
  free_ptr_t                      next_head;
  free_ptr_t                      restore_ptr;
  logic [CKPT_IDX_BITS-1:0]       write_idx;
  logic                           ring_full;
  logic                           ring_empty;
  logic                           any_valid;
  logic                           enable;
  logic                           take;

  //////////////////////////////////////////////////
  // Stall and enable
  //////////////////////////////////////////////////
  always_comb begin
    any_valid = 1'b0;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      any_valid = any_valid | rename_req.slot[s].valid;
    end
  end

  // alloc_count is the number of slots with a destination
  assign rename_stall = recover
                     || (free_count < {5'b0, alloc_count})
                     || (rename_req.take_check && ring_full);

  assign enable       = any_valid && !rename_stall;
  assign take         = enable && rename_req.take_check;
  assign result_valid = enable;

  assign rename_result.out       = rename_out;
  assign rename_result.check_idx = write_idx;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////
  rename_map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .rename_req  (rename_req),
    .enable      (enable),
    .alloc_tags  (alloc_tags),
    .restore     (recover),
    .restore_map (restore_map),
    .alloc_count (alloc_count),
    .rename_out  (rename_out),
    .next_map    (next_map)
  );

  free_list u_free_list (
    .clock       (clock),
    .reset       (reset),
    .alloc_count (alloc_count),
    .alloc_en    (enable),
    .retire      (retire),
    .restore     (recover),
    .restore_ptr (restore_ptr),
    .alloc_tags  (alloc_tags),
    .free_count  (free_count),
    .next_head   (next_head)
  );

  checkpoint_ring u_ring (
    .clock        (clock),
    .reset        (reset),
    .take         (take),
    .release_ckpt (commit_check),
    .recover      (recover),
    .recover_idx  (recover_idx),
    .write_idx    (write_idx),
    .ring_full    (ring_full),
    .ring_empty   (ring_empty)
  );

  // Both snapshots hold the state after the checkpointing group
  checkpoint_store #(.payload_t(map_snapshot_t)) u_map_store (
    .clock      (clock),
    .write_en   (take),
    .write_idx  (write_idx),
    .write_data (next_map),
    .read_idx   (recover_idx),
    .read_data  (restore_map)
  );

  checkpoint_store #(.payload_t(free_ptr_t)) u_ptr_store (
    .clock      (clock),
    .write_en   (take),
    .write_idx  (write_idx),
    .write_data (next_head),
    .read_idx   (recover_idx),
    .read_data  (restore_ptr)
  );

  // A recovery needs a live checkpoint to load from
  a_recover_live : assert property (
    @(posedge clock) disable iff (reset) recover |-> !ring_empty
  );

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
// Testbench clock and reset generator, 4 ns clock with reset held for five cycles
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Released just after the fifth rising edge
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- verification/rename_tb.sv
// Rename stage testbench with reference model, reference function and compare process
`timescale 1ns/10ps
`default_nettype none

module rename_tb import rename_pkg::*; ();

  logic                     clock;
  logic                     reset;
  rename_req_t              rename_req;
  retire_t                  retire;
  logic                     commit_check;
  logic                     recover;
  logic [CKPT_IDX_BITS-1:0] recover_idx;
  rename_result_t           rename_result;
  logic                     result_valid;
  logic                     rename_stall;

  //////////////////////////////////////////////////
  // Reference model state
  //////////////////////////////////////////////////
  phys_idx_t ref_map [ARCH_REGS];
  phys_idx_t ckpt_map [CKPT_DEPTH][ARCH_REGS];
  int        ckpt_head [CKPT_DEPTH];
  int        ckpt_pushed [CKPT_DEPTH];
  // Every tag ever queued, fl_head marks the next one to hand out
  phys_idx_t fl_tags [$];
  int        fl_head;
  // Old tags of renamed instructions, ready to retire
  phys_idx_t retire_pool [$];
  int        pool_pushed;
  int        ring_head;
  int        ring_tail;
  int        ring_count;

  int          error_count;
  int          check_count;
  int          test_count;
  int          test_start_errors;
  logic [31:0] rng_state;

  clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  rename_top DUT (
    .clock         (clock),
    .reset         (reset),
    .rename_req    (rename_req),
    .retire        (retire),
    .commit_check  (commit_check),
    .recover       (recover),
    .recover_idx   (recover_idx),
    .rename_result (rename_result),
    .result_valid  (result_valid),
    .rename_stall  (rename_stall)
  );

  //////////////////////////////////////////////////
  // Random numbers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Both slots valid, three in four carry a destination
  function automatic rename_req_t random_group();
    rename_req_t req;
    logic [31:0] r;
    req = '0;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      r = next_random();
      req.slot[s].valid  = 1'b1;
      req.slot[s].has_rd = (r[1:0] != 2'b00);
      req.slot[s].rs1    = r[6:2];
      req.slot[s].rs2    = r[11:7];
      req.slot[s].rd     = r[16:12];
    end
    return req;
  endfunction

  //////////////////////////////////////////////////
  // Reference function
  //////////////////////////////////////////////////
  function automatic rename_result_t expected_result(input rename_req_t req, input logic rec,
                                                     output logic stall);
    phys_idx_t      work [ARCH_REGS];
    rename_result_t res;
    rename_slot_t   sl;
    int             need;
    int             taken;
    work = ref_map;
    res  = '0;
    need = 0;
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      if (req.slot[s].valid && req.slot[s].has_rd) need++;
    end
    stall = rec || ((fl_tags.size() - fl_head) < need)
                || (req.take_check && ring_count == CKPT_DEPTH);
    taken = 0;
    // Older slots of the group update the working map first
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      sl = req.slot[s];
      res.out[s].prs1 = work[sl.rs1];
      res.out[s].prs2 = work[sl.rs2];
      if (sl.valid && sl.has_rd) begin
        res.out[s].prev_prd = work[sl.rd];
        if (fl_head + taken < fl_tags.size()) res.out[s].prd = fl_tags[fl_head + taken];
        work[sl.rd] = res.out[s].prd;
        taken++;
      end
    end
    res.check_idx = CKPT_IDX_BITS'(ring_tail);
    return res;
  endfunction

  // Fields of unused slots carry no meaning
  function automatic rename_result_t mask_unused(input rename_result_t res,
                                                 input rename_req_t req);
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      if (!req.slot[s].valid) begin
        res.out[s] = '0;
      end else if (!req.slot[s].has_rd) begin
        res.out[s].prd      = '0;
        res.out[s].prev_prd = '0;
      end
    end
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////
  task automatic check_result(input rename_result_t got, input rename_result_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] rename_result at %0t: got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_stall(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s at %0t: got %h expected %h", name, $time, got, exp);
    end
  endtask

  task automatic note_failure(input string what);
    error_count++;
    $display("At %0t: %s", $time, what);
  endtask

  //////////////////////////////////////////////////
  // Model update for the coming edge
  //////////////////////////////////////////////////
  task automatic update_model(input rename_req_t req, input rename_result_t res,
                              input logic accepted);
    int idx;
    if (accepted) begin
      for (int s = 0; s < RENAME_WIDTH; s++) begin
        if (req.slot[s].valid && req.slot[s].has_rd) begin
          ref_map[req.slot[s].rd] = res.out[s].prd;
          retire_pool.push_back(res.out[s].prev_prd);
          pool_pushed++;
          fl_head++;
        end
      end
      if (req.take_check) begin
        ckpt_map[ring_tail]    = ref_map;
        ckpt_head[ring_tail]   = fl_head;
        ckpt_pushed[ring_tail] = pool_pushed;
        ring_tail  = (ring_tail + 1) % CKPT_DEPTH;
        ring_count++;
      end
    end
    for (int s = 0; s < RENAME_WIDTH; s++) begin
      if (retire.slot[s].valid) fl_tags.push_back(retire.slot[s].free_tag);
    end
    if (commit_check) begin
      ring_head  = (ring_head + 1) % CKPT_DEPTH;
      ring_count--;
    end
    if (recover) begin
      idx     = int'(recover_idx);
      ref_map = ckpt_map[idx];
      fl_head = ckpt_head[idx];
      // Squashed instructions never retire their old tags
      while (pool_pushed > ckpt_pushed[idx]) begin
        void'(retire_pool.pop_back());
        pool_pushed--;
      end
      ring_tail  = (idx + 1) % CKPT_DEPTH;
      ring_count = ((idx - ring_head + CKPT_DEPTH) % CKPT_DEPTH) + 1;
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clock) begin : compare_proc
    rename_result_t exp_res;
    logic           exp_stall;
    logic           exp_valid;
    if (!reset) begin
      exp_res   = expected_result(rename_req, recover, exp_stall);
      exp_valid = (rename_req.slot[0].valid || rename_req.slot[1].valid) && !exp_stall;
      check_stall("rename_stall", rename_stall, exp_stall);
      check_stall("result_valid", result_valid, exp_valid);
      if (exp_valid) begin
        check_result(mask_unused(rename_result, rename_req), mask_unused(exp_res, rename_req));
      end
      update_model(rename_req, exp_res, exp_valid);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////
  task automatic drive(input rename_req_t req, input int nret, input logic commit,
                       input logic rec, input int rec_idx);
    retire_t ret;
    @(posedge clock);
    #1;
    ret = '0;
    for (int s = 0; s < nret && s < RENAME_WIDTH; s++) begin
      if (retire_pool.size() > 0) begin
        ret.slot[s].valid    = 1'b1;
        ret.slot[s].free_tag = retire_pool.pop_front();
      end
    end
    rename_req   = req;
    retire       = ret;
    commit_check = commit;
    recover      = rec;
    recover_idx  = CKPT_IDX_BITS'(rec_idx);
  endtask

  task automatic wait_accept(input int limit, input string what);
    bit ok;
    ok = 1'b0;
    for (int n = 0; n < limit && !ok; n++) begin
      @(negedge clock);
      ok = result_valid;
    end
    if (!ok) note_failure({"timeout waiting for ", what, " to be accepted"});
  endtask

  task automatic rename_group(input rename_req_t req, input string what);
    drive(req, 0, 1'b0, 1'b0, 0);
    wait_accept(8, what);
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("%-32s %0d errors", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin : stimulus
    rename_req_t req;
    rename_req_t young [2];
    bit          stalled;
    int          ck;
    rename_req   = '0;
    retire       = '0;
    commit_check = 1'b0;
    recover      = 1'b0;
    recover_idx  = '0;
    rng_state    = 32'h1286c14e;
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    test_start_errors = 0;
    fl_head      = 0;
    pool_pushed  = 0;
    ring_head    = 0;
    ring_tail    = 0;
    ring_count   = 0;
    for (int i = 0; i < ARCH_REGS; i++) ref_map[i] = phys_idx_t'(i);
    for (int i = 0; i < FREE_DEPTH; i++) fl_tags.push_back(phys_idx_t'(ARCH_REGS + i));

    for (int n = 0; n < 20 && reset !== 1'b0; n++) @(posedge clock);
    if (reset !== 1'b0) note_failure("reset was never released");

    // 1: identity reads and first allocations
    req = '0;
    req.slot[0] = '{valid: 1'b1, has_rd: 1'b1, rs1: 5'd3, rs2: 5'd4, rd: 5'd5};
    req.slot[1] = '{valid: 1'b1, has_rd: 1'b1, rs1: 5'd6, rs2: 5'd7, rd: 5'd8};
    rename_group(req, "first group");
    drive('0, 0, 1'b0, 1'b0, 0);
    finish_test("1 reset mapping");

    // 2: RAW and WAW inside one group
    req.slot[0] = '{valid: 1'b1, has_rd: 1'b1, rs1: 5'd1, rs2: 5'd2, rd: 5'd10};
    req.slot[1] = '{valid: 1'b1, has_rd: 1'b1, rs1: 5'd10, rs2: 5'd11, rd: 5'd10};
    rename_group(req, "WAW group");
    req.slot[0] = '{valid: 1'b1, has_rd: 1'b0, rs1: 5'd10, rs2: 5'd5, rd: 5'd12};
    req.slot[1] = '{valid: 1'b1, has_rd: 1'b1, rs1: 5'd8, rs2: 5'd10, rd: 5'd13};
    rename_group(req, "bypass group");
    finish_test("2 intra-group bypass");

    // 3: run the free list dry, then retire to resume
    stalled = 1'b0;
    for (int g = 0; g < 80 && !stalled; g++) begin
      req = random_group();
      drive(req, 0, 1'b0, 1'b0, 0);
      @(negedge clock);
      stalled = rename_stall;
    end
    if (!stalled) note_failure("free list never ran out");
    drive(req, 2, 1'b0, 1'b0, 0);
    drive(req, 0, 1'b0, 1'b0, 0);
    wait_accept(4, "held group after retirement");
    finish_test("3 free list exhaustion");

    // 4: checkpoint, younger groups, recovery
    for (int k = 0; k < 4; k++) drive('0, 2, 1'b0, 1'b0, 0);
    ck = ring_tail;
    req = random_group();
    req.take_check = 1'b1;
    rename_group(req, "checkpoint group");
    for (int k = 0; k < 2; k++) begin
      young[k] = random_group();
      young[k].slot[0].has_rd = 1'b1;
      young[k].slot[1].has_rd = 1'b1;
      rename_group(young[k], "younger group");
    end
    // Sources and destinations hit the registers the squashed groups wrote
    req = random_group();
    req.slot[0].has_rd = 1'b1;
    req.slot[0].rs1    = young[0].slot[0].rd;
    req.slot[0].rs2    = young[0].slot[1].rd;
    req.slot[0].rd     = young[1].slot[0].rd;
    req.slot[1].has_rd = 1'b1;
    req.slot[1].rs1    = young[1].slot[1].rd;
    req.slot[1].rs2    = young[0].slot[0].rd;
    req.slot[1].rd     = young[1].slot[1].rd;
    drive(req, 0, 1'b0, 1'b1, ck);
    @(negedge clock);
    if (!rename_stall) note_failure("no stall during recovery");
    drive(req, 0, 1'b0, 1'b0, 0);
    wait_accept(4, "group after recovery");
    drive('0, 0, 1'b1, 1'b0, 0);
    finish_test("4 checkpoint recovery");

    // 5: full ring holds a fifth checkpoint until a commit
    req = '0;
    req.slot[0].valid = 1'b1;
    req.slot[0].rs1   = 5'd9;
    req.take_check    = 1'b1;
    for (int k = 0; k < CKPT_DEPTH; k++) rename_group(req, "ring fill group");
    drive(req, 0, 1'b0, 1'b0, 0);
    @(negedge clock);
    if (!rename_stall) note_failure("fifth checkpoint was not stalled");
    drive(req, 0, 1'b1, 1'b0, 0);
    drive(req, 0, 1'b0, 1'b0, 0);
    wait_accept(4, "fifth checkpoint group");
    for (int k = 0; k < CKPT_DEPTH; k++) drive('0, 0, 1'b1, 1'b0, 0);
    drive('0, 0, 1'b0, 1'b0, 0);
    finish_test("5 ring full stall");

    @(posedge clock);
    $display("Tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rename.f
source/rename_pkg.sv
source/rename_map_table.sv
source/free_list.sv
source/checkpoint_store.sv
source/checkpoint_ring.sv
source/rename_top.sv
verification/clock_gen.sv
verification/rename_tb.sv
